//--- hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    // data path width
    localparam int xlen = 32;
    // register index and major opcode field widths
    localparam int reg_addr_w = 5;
    localparam int opcode_w = 7;

    // major opcodes in inst[6:0], only the ones this core runs
    typedef enum logic [opcode_w-1:0] {
        op_lui    = 7'b0110111,
        op_jal    = 7'b1101111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_imm    = 7'b0010011,
        op_reg    = 7'b0110011
    } opcode_e;

    // alu function chosen in decode
    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        // lui just passes its upper immediate
        alu_pass_b
    } alu_op_e;

endpackage

`default_nettype wire

//--- hw/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = '0
) (
    input  logic            itf,
    input  logic            arst_n,
    input  logic            pause,
    input  logic            stall,
    input  logic            redirect,
    input  logic [xlen-1:0] redirect_pc,
    output logic            imem_read,
    output logic [xlen-1:0] imem_addr,
    input  logic            imem_resp,
    input  logic [xlen-1:0] imem_rdata,
    output logic            fd_valid,
    output logic [xlen-1:0] fd_pc,
    output logic [xlen-1:0] fd_inst
);

    logic [xlen-1:0] pc;
    // low only in the first cycle out of reset
    logic            running;
    // word that came back while the pipe was frozen
    logic            hold_valid;
    logic [xlen-1:0] hold_inst;
    logic            word_ready;
    logic [xlen-1:0] word;

    // no new request while a word is parked
    assign imem_read  = running & ~hold_valid;
    assign imem_addr  = pc;
    assign word_ready = hold_valid | (imem_read & imem_resp);
    assign word       = hold_valid ? hold_inst : imem_rdata;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            pc         <= reset_vector;
            running    <= 1'b0;
            hold_valid <= 1'b0;
            fd_valid   <= 1'b0;
        end else begin
            running <= 1'b1;
            if (!pause && redirect) begin
                // pending word and fd slot both belong to the wrong path
                pc         <= redirect_pc;
                hold_valid <= 1'b0;
                fd_valid   <= 1'b0;
            end else if (!pause && !stall) begin
                fd_valid <= word_ready;
                if (word_ready) begin
                    pc         <= pc + 32'd4;
                    hold_valid <= 1'b0;
                end
            end else if (imem_read && imem_resp) begin
                hold_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (!pause && !stall && !redirect && word_ready) begin
            fd_pc   <= pc;
            fd_inst <= word;
        end
        if (imem_read && imem_resp) begin
            hold_inst <= imem_rdata;
        end
    end

    // sequential and redirected fetch addresses stay word aligned
    a_imem_aligned: assert property (@(posedge itf) disable iff (!arst_n)
        imem_read |-> imem_addr[1:0] == 2'b00);

endmodule

`default_nettype wire

//--- hw/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage import rv_pkg::*; (
    input  logic                  itf,
    input  logic                  arst_n,
    input  logic                  pause,
    input  logic                  flush,
    input  logic                  fd_valid,
    input  logic [xlen-1:0]       fd_pc,
    input  logic [xlen-1:0]       fd_inst,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic                  ex_valid,
    input  logic [reg_addr_w-1:0] mw_rd,
    input  logic                  mw_valid,
    input  logic                  wb_we,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  stall,
    output logic                  de_valid,
    output logic [xlen-1:0]       de_pc,
    output opcode_e               de_op,
    output alu_op_e               de_alu_op,
    output logic [xlen-1:0]       de_rs1_data,
    output logic [xlen-1:0]       de_rs2_data,
    output logic [xlen-1:0]       de_imm,
    output logic [reg_addr_w-1:0] de_rd,
    output logic [xlen-1:0]       de_inst
);

    logic [xlen-1:0]       regs [2**reg_addr_w];
    opcode_e               op;
    alu_op_e               alu_op;
    logic [2:0]            funct3;
    logic [reg_addr_w-1:0] rs1, rs2, rd;
    logic                  use_rs1, use_rs2;
    logic                  hazard_rs1, hazard_rs2;
    logic [xlen-1:0]       rs1_data, rs2_data;
    logic [xlen-1:0]       imm;

    assign op     = opcode_e'(fd_inst[6:0]);
    assign funct3 = fd_inst[14:12];
    assign rs1    = fd_inst[19:15];
    assign rs2    = fd_inst[24:20];
    // rd forced to 0 for branches and stores
    assign rd = (op == op_branch || op == op_store) ? '0 : fd_inst[11:7];

    // register file cleared at reset, written from the writeback register
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 2**reg_addr_w; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_we && !pause && wb_rd != '0) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // write in the same cycle shows through to the read
    assign rs1_data = (rs1 == '0) ? '0 : (wb_we && wb_rd == rs1) ? wb_data : regs[rs1];
    assign rs2_data = (rs2 == '0) ? '0 : (wb_we && wb_rd == rs2) ? wb_data : regs[rs2];

    // interlock against execute and memory, no forwarding paths
    assign use_rs1    = op != op_lui && op != op_jal;
    assign use_rs2    = op == op_branch || op == op_store || op == op_reg;
    assign hazard_rs1 = use_rs1 && rs1 != '0 &&
                        ((ex_valid && ex_rd == rs1) || (mw_valid && mw_rd == rs1));
    assign hazard_rs2 = use_rs2 && rs2 != '0 &&
                        ((ex_valid && ex_rd == rs2) || (mw_valid && mw_rd == rs2));
    assign stall      = fd_valid & (hazard_rs1 | hazard_rs2);

    // immediate by format
    always_comb begin
        case (op)
            op_lui:    imm = {fd_inst[31:12], 12'b0};
            op_jal:    imm = {{12{fd_inst[31]}}, fd_inst[19:12], fd_inst[20],
                              fd_inst[30:21], 1'b0};
            op_branch: imm = {{20{fd_inst[31]}}, fd_inst[7], fd_inst[30:25],
                              fd_inst[11:8], 1'b0};
            op_store:  imm = {{21{fd_inst[31]}}, fd_inst[30:25], fd_inst[11:7]};
            default:   imm = {{21{fd_inst[31]}}, fd_inst[30:20]};
        endcase
    end

    // add covers addresses and addi
    always_comb begin
        alu_op = alu_add;
        if (op == op_lui) begin
            alu_op = alu_pass_b;
        end else if (op == op_reg || op == op_imm) begin
            case (funct3)
                3'b100:  alu_op = alu_xor;
                3'b110:  alu_op = alu_or;
                3'b111:  alu_op = alu_and;
                // funct7 bit 5 marks sub
                default: alu_op = (op == op_reg && fd_inst[30]) ? alu_sub : alu_add;
            endcase
        end
    end

    // bubble on stall or flush
    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            de_valid <= 1'b0;
        end else if (!pause) begin
            de_valid <= fd_valid & ~stall & ~flush;
        end
    end

    always_ff @(posedge itf) begin
        if (!pause) begin
            de_pc       <= fd_pc;
            de_op       <= op;
            de_alu_op   <= alu_op;
            de_rs1_data <= rs1_data;
            de_rs2_data <= rs2_data;
            de_imm      <= imm;
            de_rd       <= rd;
            de_inst     <= fd_inst;
        end
    end

    // held-back instruction stays in the fetch/decode register, bubble goes on
    a_stall_bubble: assert property (@(posedge itf) disable iff (!arst_n)
        stall && !pause && !flush |=> !de_valid && fd_valid && $stable(fd_inst));

endmodule

`default_nettype wire

//--- hw/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage import rv_pkg::*; (
    input  logic                  itf,
    input  logic                  arst_n,
    input  logic                  pause,
    input  logic                  de_valid,
    input  logic [xlen-1:0]       de_pc,
    input  opcode_e               de_op,
    input  alu_op_e               de_alu_op,
    input  logic [xlen-1:0]       de_rs1_data,
    input  logic [xlen-1:0]       de_rs2_data,
    input  logic [xlen-1:0]       de_imm,
    input  logic [reg_addr_w-1:0] de_rd,
    input  logic [xlen-1:0]       de_inst,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc,
    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  em_valid,
    output logic [xlen-1:0]       em_pc,
    output opcode_e               em_op,
    output logic [xlen-1:0]       em_result,
    output logic [xlen-1:0]       em_store_data,
    output logic [reg_addr_w-1:0] em_rd,
    output logic [xlen-1:0]       em_inst,
    output logic [xlen-1:0]       em_rs1_data,
    output logic [xlen-1:0]       em_rs2_data
);

    logic [xlen-1:0] operand_b;
    logic [xlen-1:0] alu_out;
    logic            taken;

    // second source register only for r-type
    assign operand_b = (de_op == op_reg) ? de_rs2_data : de_imm;

    always_comb begin
        case (de_alu_op)
            alu_sub:    alu_out = de_rs1_data - operand_b;
            alu_and:    alu_out = de_rs1_data & operand_b;
            alu_or:     alu_out = de_rs1_data | operand_b;
            alu_xor:    alu_out = de_rs1_data ^ operand_b;
            alu_pass_b: alu_out = operand_b;
            default:    alu_out = de_rs1_data + operand_b;
        endcase
    end

    // funct3 bit 0 turns beq into bne
    always_comb begin
        taken = 1'b0;
        if (de_op == op_jal) begin
            taken = 1'b1;
        end else if (de_op == op_branch) begin
            taken = (de_rs1_data == de_rs2_data) ^ de_inst[12];
        end
    end

    // decode flushes on this, so the next input here is a bubble
    assign redirect    = de_valid & taken;
    assign redirect_pc = de_pc + de_imm;

    // destination seen by the decode interlock
    assign ex_valid = de_valid;
    assign ex_rd    = de_rd;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            em_valid <= 1'b0;
        end else if (!pause) begin
            em_valid <= de_valid;
        end
    end

    always_ff @(posedge itf) begin
        if (!pause) begin
            em_pc         <= de_pc;
            em_op         <= de_op;
            // link address for jal
            em_result     <= (de_op == op_jal) ? de_pc + 32'd4 : alu_out;
            em_store_data <= de_rs2_data;
            em_rd         <= de_rd;
            em_inst       <= de_inst;
            em_rs1_data   <= de_rs1_data;
            em_rs2_data   <= de_rs2_data;
        end
    end

endmodule

`default_nettype wire

//--- hw/mem_wb_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_wb_stage import rv_pkg::*; (
    input  logic                  itf,
    input  logic                  arst_n,
    input  logic                  pause,
    input  logic                  em_valid,
    input  logic [xlen-1:0]       em_pc,
    input  opcode_e               em_op,
    input  logic [xlen-1:0]       em_result,
    input  logic [xlen-1:0]       em_store_data,
    input  logic [reg_addr_w-1:0] em_rd,
    input  logic [xlen-1:0]       em_inst,
    input  logic [xlen-1:0]       em_rs1_data,
    input  logic [xlen-1:0]       em_rs2_data,
    output logic                  dmem_read,
    output logic                  dmem_write,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    input  logic                  dmem_resp,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic                  mw_valid,
    output logic [reg_addr_w-1:0] mw_rd,
    output logic                  wb_we,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data,
    output logic                  commit,
    output logic [xlen-1:0]       commit_pc,
    output logic [xlen-1:0]       commit_inst,
    output logic [reg_addr_w-1:0] commit_rd,
    output logic [xlen-1:0]       commit_rd_data,
    output logic                  commit_mem_write,
    output logic [xlen-1:0]       commit_mem_addr,
    output logic [xlen-1:0]       commit_mem_wdata,
    output logic                  halt
);

    logic            is_load, is_store;
    // access finished while the pipe was still frozen
    logic            mem_done;
    logic [xlen-1:0] load_buf, load_data, result;
    logic            wb_valid, wb_store, wb_self_jump;
    logic [xlen-1:0] wb_pc, wb_inst, wb_addr, wb_wdata;
    logic [xlen-1:0] ls_imm;

    assign is_load  = em_valid && em_op == op_load;
    assign is_store = em_valid && em_op == op_store;

    // request held until its response, never reissued
    assign dmem_read  = is_load & ~mem_done;
    assign dmem_write = is_store & ~mem_done;
    assign dmem_addr  = em_result;
    assign dmem_wdata = em_rs2_data;

    assign load_data = mem_done ? load_buf : dmem_rdata;
    // rd 0 reports zero data
    assign result = (em_rd == '0) ? '0 : (em_op == op_load) ? load_data : em_result;

    // instruction in this stage, for the decode interlock
    assign mw_valid = em_valid;
    assign mw_rd    = em_rd;

    assign wb_we            = wb_valid & (wb_rd != '0);
    assign commit           = wb_valid & ~pause;
    assign commit_pc        = wb_pc;
    assign commit_inst      = wb_inst;
    assign commit_rd        = wb_rd;
    assign commit_rd_data   = wb_data;
    assign commit_mem_write = wb_valid & wb_store;
    assign commit_mem_addr  = wb_addr;
    assign commit_mem_wdata = wb_wdata;

    always_ff @(posedge itf or negedge arst_n) begin
        if (!arst_n) begin
            mem_done <= 1'b0;
            wb_valid <= 1'b0;
            halt     <= 1'b0;
        end else begin
            if (!pause) begin
                mem_done <= 1'b0;
                wb_valid <= em_valid;
            end else if (dmem_resp) begin
                mem_done <= 1'b1;
            end
            // sticky once the self jump retires
            if (commit && wb_self_jump) begin
                halt <= 1'b1;
            end
        end
    end

    always_ff @(posedge itf) begin
        if (dmem_resp) begin
            load_buf <= dmem_rdata;
        end
        if (!pause) begin
            wb_pc        <= em_pc;
            wb_inst      <= em_inst;
            wb_rd        <= em_rd;
            wb_data      <= result;
            wb_store     <= em_op == op_store;
            wb_addr      <= em_result;
            wb_wdata     <= em_store_data;
            // jal offset of zero jumps to itself
            wb_self_jump <= em_op == op_jal && em_inst[31:12] == '0;
        end
    end

    // offset of the access as decoded upstream
    assign ls_imm = is_store ? {{21{em_inst[31]}}, em_inst[30:25], em_inst[11:7]}
                             : {{21{em_inst[31]}}, em_inst[30:20]};

    a_dmem_one_hot: assert property (@(posedge itf) disable iff (!arst_n)
        !(dmem_read && dmem_write));

    // address is rs1 plus offset through decode and the alu
    a_dmem_addr: assert property (@(posedge itf) disable iff (!arst_n)
        (dmem_read || dmem_write) |-> dmem_addr == em_rs1_data + ls_imm);

endmodule

`default_nettype wire

//--- hw/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core import rv_pkg::*; #(
    parameter logic [xlen-1:0] reset_vector = 32'h0000_0000
) (
    input  logic                  itf,
    input  logic                  arst_n,
    output logic                  imem_read,
    output logic [xlen-1:0]       imem_addr,
    input  logic                  imem_resp,
    input  logic [xlen-1:0]       imem_rdata,
    output logic                  dmem_read,
    output logic                  dmem_write,
    output logic [xlen-1:0]       dmem_addr,
    output logic [xlen-1:0]       dmem_wdata,
    input  logic                  dmem_resp,
    input  logic [xlen-1:0]       dmem_rdata,
    output logic                  commit,
    output logic [xlen-1:0]       commit_pc,
    output logic [xlen-1:0]       commit_inst,
    output logic [reg_addr_w-1:0] commit_rd,
    output logic [xlen-1:0]       commit_rd_data,
    output logic                  commit_mem_write,
    output logic [xlen-1:0]       commit_mem_addr,
    output logic [xlen-1:0]       commit_mem_wdata,
    output logic                  halt
);

    logic                  pause;
    logic                  stall, redirect;
    logic [xlen-1:0]       redirect_pc;
    // fetch to decode
    logic                  fd_valid;
    logic [xlen-1:0]       fd_pc, fd_inst;
    // decode to execute
    logic                  de_valid;
    logic [xlen-1:0]       de_pc, de_rs1_data, de_rs2_data, de_imm, de_inst;
    opcode_e               de_op;
    alu_op_e               de_alu_op;
    logic [reg_addr_w-1:0] de_rd;
    // execute to memory
    logic                  em_valid;
    logic [xlen-1:0]       em_pc, em_result, em_store_data, em_inst;
    logic [xlen-1:0]       em_rs1_data, em_rs2_data;
    opcode_e               em_op;
    logic [reg_addr_w-1:0] em_rd;
    // interlock and register file write
    logic                  ex_valid, mw_valid, wb_we;
    logic [reg_addr_w-1:0] ex_rd, mw_rd, wb_rd;
    logic [xlen-1:0]       wb_data;

    // freeze on an open fetch or a data access still waiting
    assign pause = (imem_read & ~imem_resp) | ((dmem_read | dmem_write) & ~dmem_resp);

    fetch_stage #(
        .reset_vector(reset_vector)
    ) fetch_i (.*);

    // a redirect kills the instruction sitting in decode
    decode_stage decode_i (
        .flush(redirect),
        .*
    );

    execute_stage execute_i (.*);

    mem_wb_stage mem_wb_i (.*);

endmodule

`default_nettype wire

//--- verification/rv_ref_model.svh
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// expected retire record, one per executed instruction
typedef struct packed {
    logic [xlen-1:0]       pc;
    logic [xlen-1:0]       inst;
    logic [xlen-1:0]       next_pc;
    logic [reg_addr_w-1:0] rd;
    logic [xlen-1:0]       rd_data;
    logic                  mem_write;
    logic [xlen-1:0]       mem_addr;
    logic [xlen-1:0]       mem_wdata;
} retire_rec_t;

// architectural state of the model
logic [xlen-1:0] ref_regs [2**reg_addr_w];
logic [xlen-1:0] ref_mem [data_words];
retire_rec_t     exp_q [$];

// start value of a data word, mixed from its whole byte address
function automatic logic [xlen-1:0] fill_word(input logic [xlen-1:0] addr);
    return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]} ^ 32'h0f1e_2d3c;
endfunction

// one instruction on the model state, straight from the isa rules
function automatic retire_rec_t ref_exec(input logic [xlen-1:0] pc,
                                         input logic [xlen-1:0] inst);
    retire_rec_t     rec;
    opcode_e         op;
    logic [xlen-1:0] a, b, ea, val;
    logic [xlen-1:0] imm_i, imm_s, imm_b, imm_j;
    logic            writes;
    op     = opcode_e'(inst[6:0]);
    a      = ref_regs[inst[19:15]];
    b      = ref_regs[inst[24:20]];
    imm_i  = {{20{inst[31]}}, inst[31:20]};
    imm_s  = {{20{inst[31]}}, inst[31:25], inst[11:7]};
    imm_b  = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    imm_j  = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    rec    = '0;
    rec.pc = pc;
    rec.inst = inst;
    rec.next_pc = pc + 32'd4;
    writes = 1'b1;
    val    = '0;
    case (op)
        op_lui: val = {inst[31:12], 12'b0};
        op_jal: begin
            val         = pc + 32'd4;
            rec.next_pc = pc + imm_j;
        end
        op_branch: begin
            writes = 1'b0;
            // funct3 bit 0 set means bne
            if ((a == b) != inst[12]) begin
                rec.next_pc = pc + imm_b;
            end
        end
        op_load: begin
            ea  = a + imm_i;
            val = ref_mem[ea[9:2]];
        end
        op_store: begin
            writes          = 1'b0;
            ea              = a + imm_s;
            rec.mem_write   = 1'b1;
            rec.mem_addr    = ea;
            rec.mem_wdata   = b;
            ref_mem[ea[9:2]] = b;
        end
        op_imm: val = a + imm_i;
        op_reg: begin
            case ({inst[30], inst[14:12]})
                4'b1000: val = a - b;
                4'b0100: val = a ^ b;
                4'b0110: val = a | b;
                4'b0111: val = a & b;
                default: val = a + b;
            endcase
        end
        default: writes = 1'b0;
    endcase
    // x0 writes retire as rd 0 with zero data
    if (writes && inst[11:7] != '0) begin
        rec.rd                = inst[11:7];
        rec.rd_data           = val;
        ref_regs[inst[11:7]]  = val;
    end
    return rec;
endfunction

// run the whole program on the model, up to the self jump
task automatic build_expected();
    logic [xlen-1:0] pc;
    retire_rec_t     rec;
    logic            done;
    int              i;
    for (i = 0; i < 2**reg_addr_w; i++) begin
        ref_regs[i] = '0;
    end
    for (i = 0; i < data_words; i++) begin
        ref_mem[i] = fill_word(32'(i) << 2);
    end
    exp_q.delete();
    pc   = reset_vector;
    done = 1'b0;
    i    = 0;
    // forward-only control flow, so prog_len steps is a hard bound
    while (!done && i < prog_len) begin
        rec = ref_exec(pc, prog_word(pc));
        exp_q.push_back(rec);
        done = rec.next_pc == pc;
        pc   = rec.next_pc;
        i++;
    end
endtask

task automatic compare_bit(input string what, input logic got, input logic want);
    if (got !== want) begin
        report_mismatch($sformatf("%s is %b, expected %b", what, got, want));
    end
endtask

task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] want);
    if (got !== want) begin
        report_mismatch($sformatf("pc 0x%08h, expected 0x%08h", got, want));
    end
endtask

task automatic check_inst(input logic [xlen-1:0] got, input logic [xlen-1:0] want);
    if (got !== want) begin
        report_mismatch($sformatf("inst 0x%08h, expected 0x%08h", got, want));
    end
endtask

task automatic check_reg(input logic [reg_addr_w-1:0] got_rd, input logic [xlen-1:0] got_data,
                         input logic [reg_addr_w-1:0] want_rd, input logic [xlen-1:0] want_data);
    if (got_rd !== want_rd || got_data !== want_data) begin
        report_mismatch($sformatf("rd x%0d = 0x%08h, expected x%0d = 0x%08h",
                                  got_rd, got_data, want_rd, want_data));
    end
endtask

task automatic check_store(input logic got_we, input logic [xlen-1:0] got_addr,
                           input logic [xlen-1:0] got_data, input logic want_we,
                           input logic [xlen-1:0] want_addr, input logic [xlen-1:0] want_data);
    if (got_we !== want_we) begin
        report_mismatch($sformatf("store flag %b, expected %b", got_we, want_we));
    end else if (want_we && (got_addr !== want_addr || got_data !== want_data)) begin
        report_mismatch($sformatf("store [0x%08h] = 0x%08h, expected [0x%08h] = 0x%08h",
                                  got_addr, got_data, want_addr, want_data));
    end
endtask

`endif

//--- verification/rv_core_tb.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core_tb import rv_pkg::*; ();

    // program sits away from address 0
    localparam logic [xlen-1:0] reset_vector = 32'h0000_2000;
    localparam int prog_len = 200;
    // data area covers byte addresses 0 to 1023
    localparam int data_words = 256;
    localparam int cycle_budget = prog_len * 40;
    // addi x0, x0, 0 for fetches past the program
    localparam logic [xlen-1:0] nop_word = 32'h0000_0013;

    logic                  itf;
    logic                  arst_n;
    logic                  imem_read;
    logic [xlen-1:0]       imem_addr;
    logic                  imem_resp;
    logic [xlen-1:0]       imem_rdata;
    logic                  dmem_read;
    logic                  dmem_write;
    logic [xlen-1:0]       dmem_addr;
    logic [xlen-1:0]       dmem_wdata;
    logic                  dmem_resp;
    logic [xlen-1:0]       dmem_rdata;
    logic                  commit;
    logic [xlen-1:0]       commit_pc;
    logic [xlen-1:0]       commit_inst;
    logic [reg_addr_w-1:0] commit_rd;
    logic [xlen-1:0]       commit_rd_data;
    logic                  commit_mem_write;
    logic [xlen-1:0]       commit_mem_addr;
    logic [xlen-1:0]       commit_mem_wdata;
    logic                  halt;

    logic [xlen-1:0] prog [prog_len];
    logic [xlen-1:0] dmem [data_words];
    int              imem_wait;
    int              dmem_wait;
    int              commits_seen;

    // program word at a byte address, nop outside
    function automatic logic [xlen-1:0] prog_word(input logic [xlen-1:0] addr);
        logic [xlen-1:0] offset;
        offset = addr - reset_vector;
        if (offset[1:0] == 2'b00 && offset < 32'(prog_len * 4)) begin
            return prog[int'(offset >> 2)];
        end
        return nop_word;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("[FAIL] %0d ns: %s", $time, msg);
        $display(">>> FAIL");
        $fatal(1, "retire port mismatch");
    endtask

    `include "rv_ref_model.svh"

    // instruction formats
    function automatic logic [xlen-1:0] i_type(input logic [11:0] imm,
            input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd,
            input opcode_e op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [xlen-1:0] s_type(input logic [11:0] imm,
            input logic [4:0] rs2, input logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store};
    endfunction

    function automatic logic [xlen-1:0] b_type(input logic [12:0] imm,
            input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_branch};
    endfunction

    function automatic logic [xlen-1:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    // random program, small register set for many dependencies
    task automatic build_program();
        int                    idx;
        int                    kind;
        int                    ahead;
        int                    sel;
        logic [reg_addr_w-1:0] rd, rs1, rs2;
        logic [2:0]            f3;
        logic [6:0]            f7;
        for (idx = 0; idx < prog_len - 1; idx++) begin
            kind = int'($urandom_range(11, 0));
            rd   = reg_addr_w'($urandom_range(7, 0));
            rs1  = reg_addr_w'($urandom_range(7, 0));
            rs2  = reg_addr_w'($urandom_range(7, 0));
            // forward target, at most the final self jump
            ahead = int'($urandom_range(6, 1));
            if (idx + ahead > prog_len - 1) begin
                ahead = prog_len - 1 - idx;
            end
            case (kind)
                0: prog[idx] = {20'($urandom), rd, op_lui};
                1: prog[idx] = j_type(21'(ahead * 4), rd);
                // kind 2 beq, kind 3 bne
                2, 3: prog[idx] = b_type(13'(ahead * 4), rs2, rs1, {2'b00, kind[0]});
                // x0 base keeps word addresses inside the data area
                4: prog[idx] = i_type({2'b00, 8'($urandom), 2'b00}, 5'd0, 3'b010, rd, op_load);
                5: prog[idx] = s_type({2'b00, 8'($urandom), 2'b00}, rs2, 5'd0);
                6, 7: prog[idx] = i_type(12'($urandom), rs1, 3'b000, rd, op_imm);
                default: begin
                    sel = int'($urandom_range(4, 0));
                    f3  = (sel == 2) ? 3'b100 : (sel == 3) ? 3'b110 :
                          (sel == 4) ? 3'b111 : 3'b000;
                    f7  = (sel == 1) ? 7'b0100000 : 7'b0000000;
                    prog[idx] = {f7, rs2, rs1, f3, rd, op_reg};
                end
            endcase
        end
        // jal x0, 0 ends the run
        prog[prog_len-1] = j_type(21'd0, 5'd0);
    endtask

    rv_core #(
        .reset_vector(reset_vector)
    ) dut_i (.*);

    initial begin
        itf = 1'b0;
        forever begin
            #5 itf = ~itf;
        end
    end

    // instruction memory, 1 to 3 wait cycles per request
    initial begin
        imem_resp  = 1'b0;
        imem_rdata = '0;
        imem_wait  = 1;
        forever begin
            @(posedge itf);
            #1;
            imem_resp = 1'b0;
            if (imem_read) begin
                if (imem_wait == 0) begin
                    imem_resp  = 1'b1;
                    imem_rdata = prog_word(imem_addr);
                    imem_wait  = int'($urandom_range(3, 1));
                end else begin
                    imem_wait--;
                end
            end
        end
    end

    // data memory, write lands on the response
    initial begin
        dmem_resp  = 1'b0;
        dmem_rdata = '0;
        dmem_wait  = 1;
        forever begin
            @(posedge itf);
            #1;
            dmem_resp = 1'b0;
            if (dmem_read || dmem_write) begin
                if (dmem_addr >= 32'(data_words * 4) || dmem_addr[1:0] != 2'b00) begin
                    report_mismatch($sformatf("data access at 0x%08h", dmem_addr));
                end else if (dmem_wait == 0) begin
                    dmem_resp = 1'b1;
                    if (dmem_write) begin
                        dmem[dmem_addr[9:2]] = dmem_wdata;
                    end else begin
                        dmem_rdata = dmem[dmem_addr[9:2]];
                    end
                    dmem_wait = int'($urandom_range(3, 1));
                end else begin
                    dmem_wait--;
                end
            end
        end
    end

    // reset, first fetch, then compare every commit with the model
    initial begin
        retire_rec_t want;
        int          i;
        void'($urandom(32'hc14d56ff));
        arst_n       = 1'b0;
        commits_seen = 0;
        build_program();
        build_expected();
        for (i = 0; i < data_words; i++) begin
            dmem[i] = fill_word(32'(i) << 2);
        end
        @(negedge itf);
        compare_bit("commit in reset", commit, 1'b0);
        compare_bit("imem_read in reset", imem_read, 1'b0);
        compare_bit("dmem_read in reset", dmem_read, 1'b0);
        compare_bit("dmem_write in reset", dmem_write, 1'b0);
        compare_bit("halt in reset", halt, 1'b0);
        @(posedge itf);
        #1;
        arst_n = 1'b1;
        // request comes one cycle after release
        @(negedge itf);
        compare_bit("imem_read in release cycle", imem_read, 1'b0);
        @(negedge itf);
        compare_bit("first imem_read", imem_read, 1'b1);
        check_pc(imem_addr, reset_vector);
        while (halt !== 1'b1) begin
            @(negedge itf);
            if (commit === 1'b1 && halt !== 1'b1) begin
                if (commits_seen >= exp_q.size()) begin
                    report_mismatch($sformatf("extra commit at pc 0x%08h", commit_pc));
                end else begin
                    want = exp_q[commits_seen];
                    check_pc(commit_pc, want.pc);
                    check_inst(commit_inst, want.inst);
                    check_reg(commit_rd, commit_rd_data, want.rd, want.rd_data);
                    check_store(commit_mem_write, commit_mem_addr, commit_mem_wdata,
                                want.mem_write, want.mem_addr, want.mem_wdata);
                    commits_seen++;
                end
            end
        end
        if (commits_seen == exp_q.size()) begin
            $display(">>> PASS");
            $finish;
        end else begin
            $display("halt after %0d commits, reference has %0d", commits_seen, exp_q.size());
            $display(">>> FAIL");
            $fatal(1, "commit count differs from reference");
        end
    end

    // budget of 40 cycles per program word
    initial begin
        repeat (cycle_budget) @(posedge itf);
        $display("timeout: no halt within %0d cycles, %0d commits seen",
                 cycle_budget, commits_seen);
        $display(">>> FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- rv_core.f
+incdir+verification
hw/rv_pkg.sv
hw/fetch_stage.sv
hw/decode_stage.sv
hw/execute_stage.sv
hw/mem_wb_stage.sv
hw/rv_core.sv
verification/rv_core_tb.sv

//--- Makefile
# verilator build and run of the core testbench

sim:
	verilator --binary --timing --assert -j 0 --top-module rv_core_tb -f rv_core.f
	./obj_dir/Vrv_core_tb

clean:
	rm -rf obj_dir

.PHONY: sim clean
